// File: hdl/cpu_pkg.sv
package cpu_pkg;

    // Core data path width.
    localparam int unsigned XLEN = 32;

    // Data word or byte address.
    typedef logic [XLEN-1:0] word_t;

    // Byte distance between consecutive instructions.
    localparam word_t INST_BYTES = word_t'(4);

endpackage

// File: hdl/cp0_pkg.sv
package cp0_pkg;

    import cpu_pkg::*;

    typedef logic [4:0] cp0_addr_t;
    typedef logic [4:0] exccode_t;

    // Exception codes.
    localparam exccode_t EXC_INT  = 5'd0;
    localparam exccode_t EXC_ADEL = 5'd4;
    localparam exccode_t EXC_ADES = 5'd5;
    localparam exccode_t EXC_SYS  = 5'd8;
    localparam exccode_t EXC_BP   = 5'd9;
    localparam exccode_t EXC_RI   = 5'd10;
    localparam exccode_t EXC_OV   = 5'd12;

    // Register numbers.
    localparam cp0_addr_t CP0_BADVADDR = 5'd8;
    localparam cp0_addr_t CP0_STATUS   = 5'd12;
    localparam cp0_addr_t CP0_CAUSE    = 5'd13;
    localparam cp0_addr_t CP0_EPC      = 5'd14;

    // Field positions.
    localparam int unsigned STATUS_IE    = 0;
    localparam int unsigned STATUS_EXL   = 1;
    localparam int unsigned STATUS_IM_LO = 8;
    localparam int unsigned STATUS_BEV   = 22;
    localparam int unsigned CAUSE_BD     = 31;
    localparam int unsigned CAUSE_IP_LO  = 8;
    localparam int unsigned CAUSE_EXC_LO = 2;

    // Hardware interrupt bits sit above the software ones in IP.
    localparam int unsigned HW_INT_NUM = 6;
    localparam int unsigned SW_INT_NUM = 2;
    localparam int unsigned IP_NUM     = HW_INT_NUM + SW_INT_NUM;

    // Only BEV set out of reset.
    localparam word_t STATUS_RESET = 32'h0040_0000;

    localparam word_t EXC_VECTOR = 32'hbfc0_0380;

endpackage

// File: hdl/exc_commit_if.sv
`timescale 1ns/10ps

interface exc_commit_if
    import cpu_pkg::*;
    import cp0_pkg::*;
();

    // Commit of the retiring instruction.
    logic     take;
    logic     eret;
    word_t    epc;
    logic     bd;
    word_t    badvaddr;
    logic     badvaddr_wren;
    exccode_t exccode;

    // Interrupt and return state from CP0.
    logic     int_pending;
    logic     exl;
    word_t    epc_val;

    modport arb (
        output take, eret, epc, bd, badvaddr, badvaddr_wren, exccode,
        input  int_pending, exl, epc_val
    );

    modport regs (
        input  take, eret, epc, bd, badvaddr, badvaddr_wren, exccode,
        output int_pending, exl, epc_val
    );

endinterface

// File: hdl/exc_arbiter.sv
`timescale 1ns/10ps

module exc_arbiter
    import cpu_pkg::*;
    import cp0_pkg::*;
(
    input  logic       aclk,
    input  logic       rst_n,
    input  logic       inst_valid,
    input  word_t      inst_pc,
    input  logic       inst_bd,
    input  logic       inst_eret,
    input  logic       if_adel,
    input  logic       dec_exc,
    input  exccode_t   dec_exccode,
    input  logic       exe_exc,
    input  exccode_t   exe_exccode,
    input  word_t      exe_badvaddr,
    exc_commit_if.arb  commit,
    output logic       flush,
    output word_t      flush_pc
);

    logic     exc_hit;
    exccode_t exc_code;
    word_t    bad_addr;
    logic     bad_wren;
    word_t    restart_pc;

    // Interrupt first, then the oldest stage.
    always_comb begin
        exc_hit  = 1'b1;
        exc_code = EXC_INT;
        bad_addr = inst_pc;
        bad_wren = 1'b0;
        if (commit.int_pending) begin
            exc_code = EXC_INT;
        end else if (if_adel) begin
            exc_code = EXC_ADEL;
            bad_wren = 1'b1;
        end else if (dec_exc) begin
            exc_code = dec_exccode;
        end else if (exe_exc) begin
            exc_code = exe_exccode;
            bad_addr = exe_badvaddr;
            bad_wren = (exe_exccode == EXC_ADEL) || (exe_exccode == EXC_ADES);
        end else begin
            exc_hit = 1'b0;
        end
    end

    // A delay slot restarts at its branch.
    assign restart_pc = inst_bd ? inst_pc - INST_BYTES : inst_pc;

    assign commit.take          = inst_valid & exc_hit;
    assign commit.eret          = inst_valid & ~exc_hit & inst_eret;
    // Nested exception keeps the first EPC.
    assign commit.epc           = commit.exl ? commit.epc_val : restart_pc;
    assign commit.bd            = inst_bd;
    assign commit.badvaddr      = bad_addr;
    assign commit.badvaddr_wren = bad_wren;
    assign commit.exccode       = exc_code;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            flush <= 1'b0;
        end else begin
            flush <= commit.take | commit.eret;
        end
    end

    // Held between flushes.
    always_ff @(posedge aclk) begin
        if (commit.take) begin
            flush_pc <= EXC_VECTOR;
        end else if (commit.eret) begin
            flush_pc <= commit.epc_val;
        end
    end

endmodule

// File: hdl/cp0_regs.sv
`timescale 1ns/10ps

module cp0_regs
    import cpu_pkg::*;
    import cp0_pkg::*;
(
    input  logic                  aclk,
    input  logic                  rst_n,
    input  logic [HW_INT_NUM-1:0] hw_int,
    exc_commit_if.regs            commit,
    input  logic                  mtc0_valid,
    input  cp0_addr_t             mtc0_addr,
    input  word_t                 mtc0_wdata,
    input  cp0_addr_t             mfc0_addr,
    output word_t                 mfc0_rdata
);

    word_t status_q;
    word_t cause_q;
    word_t epc_q;
    word_t badvaddr_q;

    logic status_wr;
    logic cause_wr;
    logic epc_wr;
    logic [IP_NUM-1:0] ip_masked;

    // An exception on the same instruction cancels the write.
    assign status_wr = mtc0_valid & ~commit.take & (mtc0_addr == CP0_STATUS);
    assign cause_wr  = mtc0_valid & ~commit.take & (mtc0_addr == CP0_CAUSE);
    assign epc_wr    = mtc0_valid & ~commit.take & (mtc0_addr == CP0_EPC);

    // BEV stays as reset left it.
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            status_q <= STATUS_RESET;
        end else if (commit.take) begin
            status_q[STATUS_EXL] <= 1'b1;
        end else begin
            if (status_wr) begin
                status_q[STATUS_IM_LO +: IP_NUM] <= mtc0_wdata[STATUS_IM_LO +: IP_NUM];
                status_q[STATUS_EXL]             <= mtc0_wdata[STATUS_EXL];
                status_q[STATUS_IE]              <= mtc0_wdata[STATUS_IE];
            end
            // Return overrides a write to EXL.
            if (commit.eret) begin
                status_q[STATUS_EXL] <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            cause_q <= '0;
        end else begin
            // Hardware lines land one edge late.
            cause_q[CAUSE_IP_LO + SW_INT_NUM +: HW_INT_NUM] <= hw_int;
            if (commit.take) begin
                cause_q[CAUSE_EXC_LO +: $bits(exccode_t)] <= commit.exccode;
                if (!status_q[STATUS_EXL]) begin
                    cause_q[CAUSE_BD] <= commit.bd;
                end
            end else if (cause_wr) begin
                cause_q[CAUSE_IP_LO +: SW_INT_NUM] <= mtc0_wdata[CAUSE_IP_LO +: SW_INT_NUM];
            end
        end
    end

    // Arbiter already holds EPC when EXL is set.
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            epc_q <= '0;
        end else if (commit.take) begin
            epc_q <= commit.epc;
        end else if (epc_wr) begin
            epc_q <= mtc0_wdata;
        end
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            badvaddr_q <= '0;
        end else if (commit.take && commit.badvaddr_wren) begin
            badvaddr_q <= commit.badvaddr;
        end
    end

    assign ip_masked = cause_q[CAUSE_IP_LO +: IP_NUM] & status_q[STATUS_IM_LO +: IP_NUM];

    assign commit.int_pending = status_q[STATUS_IE] & ~status_q[STATUS_EXL] & (|ip_masked);
    assign commit.exl         = status_q[STATUS_EXL];
    assign commit.epc_val     = epc_q;

    always_comb begin
        case (mfc0_addr)
            CP0_BADVADDR: mfc0_rdata = badvaddr_q;
            CP0_STATUS:   mfc0_rdata = status_q;
            CP0_CAUSE:    mfc0_rdata = cause_q;
            CP0_EPC:      mfc0_rdata = epc_q;
            default:      mfc0_rdata = '0;
        endcase
    end

endmodule

// File: hdl/exc_unit_top.sv
`timescale 1ns/10ps

module exc_unit_top
    import cpu_pkg::*;
    import cp0_pkg::*;
(
    input  logic                  aclk,
    input  logic                  rst_n,
    input  logic [HW_INT_NUM-1:0] hw_int,

    input  logic                  inst_valid,
    input  word_t                 inst_pc,
    input  logic                  inst_bd,
    input  logic                  inst_eret,

    input  logic                  if_adel,
    input  logic                  dec_exc,
    input  exccode_t              dec_exccode,
    input  logic                  exe_exc,
    input  exccode_t              exe_exccode,
    input  word_t                 exe_badvaddr,

    input  logic                  mtc0_wen,
    input  cp0_addr_t             mtc0_addr,
    input  word_t                 mtc0_wdata,
    input  cp0_addr_t             mfc0_addr,
    output word_t                 mfc0_rdata,

    output logic                  flush,
    output word_t                 flush_pc
);

    logic mtc0_valid;

    exc_commit_if commit ();

    // Writes retire with their instruction.
    assign mtc0_valid = inst_valid & mtc0_wen;

    exc_arbiter u_arbiter (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .inst_valid   (inst_valid),
        .inst_pc      (inst_pc),
        .inst_bd      (inst_bd),
        .inst_eret    (inst_eret),
        .if_adel      (if_adel),
        .dec_exc      (dec_exc),
        .dec_exccode  (dec_exccode),
        .exe_exc      (exe_exc),
        .exe_exccode  (exe_exccode),
        .exe_badvaddr (exe_badvaddr),
        .commit       (commit.arb),
        .flush        (flush),
        .flush_pc     (flush_pc)
    );

    cp0_regs u_cp0 (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .hw_int     (hw_int),
        .commit     (commit.regs),
        .mtc0_valid (mtc0_valid),
        .mtc0_addr  (mtc0_addr),
        .mtc0_wdata (mtc0_wdata),
        .mfc0_addr  (mfc0_addr),
        .mfc0_rdata (mfc0_rdata)
    );

endmodule

// File: sim/tb_exc_unit.sv
`timescale 1ns/10ps

module tb_exc_unit
    import cpu_pkg::*;
    import cp0_pkg::*;
();

    localparam int unsigned RESET_CYCLES    = 5;
    localparam int unsigned DIRECTED_CYCLES = 40;
    localparam int unsigned RAND_CYCLES     = 2000;
    localparam int unsigned CYCLE_LIMIT     = RESET_CYCLES + DIRECTED_CYCLES + RAND_CYCLES + 100;

    typedef struct packed {
        word_t status;
        word_t cause;
        word_t epc;
        word_t badvaddr;
        logic  flush;
        word_t flush_pc;
    } model_t;

    logic                  aclk;
    logic                  rst_n;
    logic [HW_INT_NUM-1:0] hw_int;
    logic                  inst_valid;
    word_t                 inst_pc;
    logic                  inst_bd;
    logic                  inst_eret;
    logic                  if_adel;
    logic                  dec_exc;
    exccode_t              dec_exccode;
    logic                  exe_exc;
    exccode_t              exe_exccode;
    word_t                 exe_badvaddr;
    logic                  mtc0_wen;
    cp0_addr_t             mtc0_addr;
    word_t                 mtc0_wdata;
    cp0_addr_t             mfc0_addr;
    word_t                 mfc0_rdata;
    logic                  flush;
    word_t                 flush_pc;

    model_t      model;
    int unsigned cycles = 0;

    // Register 3 stands for any unlisted number.
    cp0_addr_t read_addrs[5] = '{CP0_BADVADDR, CP0_STATUS, CP0_CAUSE, CP0_EPC, 5'd3};
    exccode_t  dec_codes[3]  = '{EXC_SYS, EXC_BP, EXC_RI};
    exccode_t  exe_codes[3]  = '{EXC_ADEL, EXC_ADES, EXC_OV};

    exc_unit_top UUT (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .hw_int       (hw_int),
        .inst_valid   (inst_valid),
        .inst_pc      (inst_pc),
        .inst_bd      (inst_bd),
        .inst_eret    (inst_eret),
        .if_adel      (if_adel),
        .dec_exc      (dec_exc),
        .dec_exccode  (dec_exccode),
        .exe_exc      (exe_exc),
        .exe_exccode  (exe_exccode),
        .exe_badvaddr (exe_badvaddr),
        .mtc0_wen     (mtc0_wen),
        .mtc0_addr    (mtc0_addr),
        .mtc0_wdata   (mtc0_wdata),
        .mfc0_addr    (mfc0_addr),
        .mfc0_rdata   (mfc0_rdata),
        .flush        (flush),
        .flush_pc     (flush_pc)
    );

    always #4 aclk = ~aclk;

    // Next CP0 state and flush for the inputs at this edge.
    function automatic model_t next_model(model_t m);
        model_t   n;
        logic     pending;
        logic     take;
        exccode_t code;
        n        = m;
        n.flush  = 1'b0;
        pending  = m.status[0] && !m.status[1] && (|(m.cause[15:8] & m.status[15:8]));
        take     = 1'b1;
        code     = EXC_INT;
        n.cause[15:10] = hw_int;
        if (inst_valid) begin
            if (pending) begin
                code = EXC_INT;
            end else if (if_adel) begin
                code       = EXC_ADEL;
                n.badvaddr = inst_pc;
            end else if (dec_exc) begin
                code = dec_exccode;
            end else if (exe_exc) begin
                code = exe_exccode;
                if (exe_exccode == EXC_ADEL || exe_exccode == EXC_ADES) begin
                    n.badvaddr = exe_badvaddr;
                end
            end else begin
                take = 1'b0;
            end
            if (take) begin
                if (!m.status[1]) begin
                    n.epc       = inst_bd ? inst_pc - 32'd4 : inst_pc;
                    n.cause[31] = inst_bd;
                end
                n.cause[6:2] = code;
                n.status[1]  = 1'b1;
                n.flush      = 1'b1;
                n.flush_pc   = 32'hbfc0_0380;
            end else begin
                if (mtc0_wen) begin
                    case (mtc0_addr)
                        CP0_STATUS: begin
                            n.status[15:8] = mtc0_wdata[15:8];
                            n.status[1:0]  = mtc0_wdata[1:0];
                        end
                        CP0_CAUSE: n.cause[9:8] = mtc0_wdata[9:8];
                        CP0_EPC:   n.epc = mtc0_wdata;
                        default:   ;
                    endcase
                end
                if (inst_eret) begin
                    n.status[1] = 1'b0;
                    n.flush     = 1'b1;
                    n.flush_pc  = m.epc;
                end
            end
        end
        return n;
    endfunction

    function automatic word_t expected_read(model_t m, cp0_addr_t addr);
        case (addr)
            CP0_BADVADDR: return m.badvaddr;
            CP0_STATUS:   return m.status;
            CP0_CAUSE:    return m.cause;
            CP0_EPC:      return m.epc;
            default:      return '0;
        endcase
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            $display("TEST FAIL");
            $fatal(1, "Compare failed on %s", name);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            $display("TEST FAIL");
            $fatal(1, "Compare failed on %s", name);
        end
    endtask

    // Outputs still hold the pre-edge state here.
    always @(posedge aclk) begin
        if (!rst_n) begin
            model        = '0;
            model.status = STATUS_RESET;
        end else begin
            check_bit("flush", flush, model.flush);
            if (model.flush) begin
                check_word("flush_pc", flush_pc, model.flush_pc);
            end
            check_word("mfc0_rdata", mfc0_rdata, expected_read(model, mfc0_addr));
            model = next_model(model);
        end
    end

    always @(posedge aclk) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("Run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAIL");
            $fatal(1, "Timeout");
        end
    end

    task automatic clear_inputs();
        inst_valid   = 1'b0;
        inst_pc      = '0;
        inst_bd      = 1'b0;
        inst_eret    = 1'b0;
        if_adel      = 1'b0;
        dec_exc      = 1'b0;
        dec_exccode  = '0;
        exe_exc      = 1'b0;
        exe_exccode  = '0;
        exe_badvaddr = '0;
        mtc0_wen     = 1'b0;
        mtc0_addr    = '0;
        mtc0_wdata   = '0;
    endtask

    task automatic next_cycle();
        @(negedge aclk);
        clear_inputs();
        mfc0_addr = read_addrs[$urandom_range(4, 0)];
    endtask

    task automatic retire(input word_t pc, input logic bd);
        next_cycle();
        inst_valid = 1'b1;
        inst_pc    = pc;
        inst_bd    = bd;
    endtask

    task automatic write_cp0(input cp0_addr_t addr, input word_t data);
        mtc0_wen   = 1'b1;
        mtc0_addr  = addr;
        mtc0_wdata = data;
    endtask

    initial begin
        void'($urandom(32'ha991));
        aclk      = 1'b0;
        rst_n     = 1'b0;
        hw_int    = '0;
        mfc0_addr = '0;
        clear_inputs();
        repeat (RESET_CYCLES) @(negedge aclk);
        rst_n = 1'b1;
        for (int i = 0; i < 5; i++) begin
            @(negedge aclk);
            mfc0_addr = read_addrs[i];
        end

        // IE, EXL and all IM bits, then a software interrupt held off by EXL.
        retire(32'h0000_1000, 1'b0);
        write_cp0(CP0_STATUS, 32'h0000_ff03);
        retire(32'h0000_1004, 1'b0);
        write_cp0(CP0_CAUSE, 32'h0000_0300);
        retire(32'h0000_1008, 1'b0);
        inst_eret = 1'b1;
        retire(32'h0000_2000, 1'b0);
        // Nested exception in a delay slot.
        retire(32'h0000_3004, 1'b1);
        dec_exc     = 1'b1;
        dec_exccode = EXC_SYS;
        retire(32'h0000_3008, 1'b0);
        write_cp0(CP0_CAUSE, 32'h0000_0000);
        inst_eret = 1'b1;
        retire(32'h0000_4008, 1'b1);
        exe_exc      = 1'b1;
        exe_exccode  = EXC_ADES;
        exe_badvaddr = 32'hdead_beef;
        retire(32'h0000_4100, 1'b0);
        write_cp0(CP0_EPC, 32'h0000_5000);
        if_adel = 1'b1;
        retire(32'h0000_4104, 1'b0);
        write_cp0(CP0_BADVADDR, 32'hffff_ffff);
        inst_eret = 1'b1;
        retire(32'h0000_4108, 1'b0);
        write_cp0(5'd3, 32'hffff_ffff);
        retire(32'h0000_410c, 1'b0);
        write_cp0(CP0_STATUS, 32'h0000_ff03);
        inst_eret = 1'b1;
        // Hardware line seen one edge after it rises.
        retire(32'h0000_4ff0, 1'b0);
        hw_int = 6'b000100;
        retire(32'h0000_5000, 1'b0);
        retire(32'h0000_6000, 1'b0);
        hw_int    = '0;
        inst_eret = 1'b1;

        repeat (RAND_CYCLES) begin
            next_cycle();
            inst_valid   = ($urandom_range(3, 0) != 0);
            inst_pc      = $urandom() & 32'hffff_fffc;
            inst_bd      = ($urandom_range(3, 0) == 0);
            inst_eret    = ($urandom_range(5, 0) == 0);
            if_adel      = ($urandom_range(15, 0) == 0);
            dec_exc      = ($urandom_range(9, 0) == 0);
            dec_exccode  = dec_codes[$urandom_range(2, 0)];
            exe_exc      = ($urandom_range(9, 0) == 0);
            exe_exccode  = exe_codes[$urandom_range(2, 0)];
            exe_badvaddr = $urandom();
            if ($urandom_range(3, 0) == 0) begin
                write_cp0(read_addrs[$urandom_range(4, 0)], $urandom());
            end
            if ($urandom_range(15, 0) == 0) begin
                hw_int = HW_INT_NUM'($urandom_range(63, 0));
            end
        end

        next_cycle();
        repeat (2) @(negedge aclk);
        $display("TEST PASS");
        $finish;
    end

endmodule

// File: verilog.f
hdl/cpu_pkg.sv
hdl/cp0_pkg.sv
hdl/exc_commit_if.sv
hdl/exc_arbiter.sv
hdl/cp0_regs.sv
hdl/exc_unit_top.sv
sim/tb_exc_unit.sv

// File: Bender.yml
package:
  name: exc_unit

sources:
  - files:
      - hdl/cpu_pkg.sv
      - hdl/cp0_pkg.sv
      - hdl/exc_commit_if.sv
      - hdl/exc_arbiter.sv
      - hdl/cp0_regs.sv
      - hdl/exc_unit_top.sv
  - target: simulation
    files:
      - sim/tb_exc_unit.sv
